// File: dai_top.f
src/dai_cfg_pkg.sv
src/dai_frame_pkg.sv
src/dai_bclk_gen.sv
src/dai_frame_ctrl.sv
src/dai_rx_deser.sv
src/dai_tx_ser.sv
src/dai_top.sv
tb/tb_dai_codec.sv
tb/tb_dai_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dai_top
FILELIST  ?= dai_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_dai_top.sv
`timescale 1ns/1ps

module tb_dai_top;

  localparam int sw = dai_frame_pkg::sample_width;
  localparam int cycle_limit = 4 * 36 * 16 * 4 + 6 * 2 * 20 * 8 + 1000;

  logic RESET;
  logic bclk_ok;
  logic master_i;
  logic [dai_cfg_pkg::mode_width-1:0] mode_i;
  logic [sw-1:0] tx_left_i;
  logic [sw-1:0] tx_right_i;
  wire  bclk_i;
  wire  lrck_i;
  wire  din_i;
  logic bclk_o;
  logic lrck_o;
  logic dout_o;
  logic [sw-1:0] rx_left_o;
  logic [sw-1:0] rx_right_o;
  logic data_latch_o;

  logic idle_ph;
  logic master_ph;
  logic slave_ph;
  logic codec_en;
  logic tx_stable;
  logic [15:0] lfsr_q;
  logic [19:0] codec_word;
  logic codec_din;
  logic codec_take;
  logic codec_chk;
  logic codec_exp;
  logic [15:0] sent_left;
  logic [15:0] sent_right;

  logic bclk_q;
  logic lrck_q;
  logic bclk_tog;
  logic lrck_chg;
  logic [4:0] gap;
  logic gap_valid;
  logic [6:0] tog_cnt;
  logic [6:0] tog_total;
  logic frame_valid;
  logic [3:0] latch_in_period;
  logic [3:0] latch_total;
  logic period_valid;
  int   latch_cnt;
  int   cycles = 0;

  dai_top #(
    .SYNC_STAGES (2)
  ) dut0 (
    .RESET        (RESET),
    .bclk_ok      (bclk_ok),
    .master_i     (master_i),
    .mode_i       (mode_i),
    .bclk_i       (bclk_i),
    .lrck_i       (lrck_i),
    .din_i        (din_i),
    .tx_left_i    (tx_left_i),
    .tx_right_i   (tx_right_i),
    .bclk_o       (bclk_o),
    .lrck_o       (lrck_o),
    .dout_o       (dout_o),
    .rx_left_o    (rx_left_o),
    .rx_right_o   (rx_right_o),
    .data_latch_o (data_latch_o)
  );

  tb_dai_codec codec0 (
    .clk_i        (RESET),
    .rst_i        (bclk_ok),
    .en_i         (codec_en),
    .slot_word_i  (codec_word),
    .tx_left_i    (tx_left_i),
    .tx_right_i   (tx_right_i),
    .bclk_o       (bclk_i),
    .lrck_o       (lrck_i),
    .din_o        (codec_din),
    .take_o       (codec_take),
    .sent_left_o  (sent_left),
    .sent_right_o (sent_right),
    .chk_o        (codec_chk),
    .exp_bit_o    (codec_exp)
  );

  // Master phase loops dout back into the receiver.
  assign din_i = master_i ? dout_o : codec_din;

  initial begin
    RESET = 1'b0;
    forever #50 RESET = ~RESET;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [4:0] expected_half(input logic [1:0] mode);
    return 5'd1 << mode;
  endfunction

  task automatic draw_bits(input int n, output logic [19:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[18:0], lfsr_q[0]};
    end
  endtask

  task automatic fail_now(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic apply_reset();
    bclk_ok <= 1'b1;
    repeat (2) @(posedge RESET);
    bclk_ok <= 1'b0;
  endtask

  task automatic wait_latches(input int n);
    while (latch_cnt < n) begin
      @(posedge RESET);
    end
  endtask

  // New transmit samples after every second frame latch.
  always @(posedge RESET) begin : drive_samples
    logic [19:0] w;
    if (bclk_ok) begin
      tx_stable <= 1'b0;
    end else if (data_latch_o && (master_ph || slave_ph)) begin
      if (tx_stable) begin
        draw_bits(16, w);
        tx_left_i <= w[15:0];
        draw_bits(16, w);
        tx_right_i <= w[15:0];
        tx_stable <= 1'b0;
      end else begin
        tx_stable <= 1'b1;
      end
    end
    if (codec_take) begin
      draw_bits(20, w);
      codec_word <= w;
    end
  end

  assign bclk_tog    = bclk_o != bclk_q;
  assign lrck_chg    = lrck_o != lrck_q;
  assign tog_total   = tog_cnt + 7'(bclk_tog);
  assign latch_total = latch_in_period + 4'(data_latch_o);

  always @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      bclk_q          <= 1'b0;
      lrck_q          <= 1'b0;
      gap             <= '0;
      gap_valid       <= 1'b0;
      tog_cnt         <= '0;
      frame_valid     <= 1'b0;
      latch_in_period <= '0;
      period_valid    <= 1'b0;
      latch_cnt       <= 0;
    end else begin
      bclk_q <= bclk_o;
      lrck_q <= lrck_o;
      if (bclk_tog) begin
        gap       <= 5'd1;
        gap_valid <= 1'b1;
      end else if (gap != '1) begin
        gap <= gap + 5'd1;
      end
      if (lrck_chg) begin
        tog_cnt     <= '0;
        frame_valid <= 1'b1;
      end else begin
        tog_cnt <= tog_total;
      end
      if (lrck_chg && lrck_o) begin
        latch_in_period <= '0;
        period_valid    <= 1'b1;
      end else begin
        latch_in_period <= latch_total;
      end
      if (data_latch_o) begin
        latch_cnt <= latch_cnt + 1;
      end
    end
  end

  always @(posedge RESET) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  a_idle: assert property (@(posedge RESET) disable iff (bclk_ok || !idle_ph)
    !bclk_o && !lrck_o && !dout_o && !data_latch_o)
    else fail_now("outputs not low after reset");

  a_ratio: assert property (@(posedge RESET) disable iff (bclk_ok)
    master_ph && gap_valid && bclk_tog |-> gap == expected_half(mode_i))
    else fail_now("bclk_o half period does not match mode_i");

  a_frame: assert property (@(posedge RESET) disable iff (bclk_ok)
    master_ph && frame_valid && lrck_chg |-> tog_total == 7'd36)
    else fail_now("lrck_o slot is not 36 bclk_o toggles long");

  a_latch_once: assert property (@(posedge RESET) disable iff (bclk_ok)
    master_ph && period_valid && lrck_chg && lrck_o |-> latch_total == 4'd1)
    else fail_now("data_latch_o count per lrck_o period is not one");

  a_loopback: assert property (@(posedge RESET) disable iff (bclk_ok)
    master_ph && data_latch_o && tx_stable |->
      rx_left_o == tx_left_i && rx_right_o == tx_right_i)
    else fail_now("loopback samples differ from transmitted samples");

  a_slave_quiet: assert property (@(posedge RESET) disable iff (bclk_ok)
    !master_i |-> !bclk_o && !lrck_o)
    else fail_now("bclk_o or lrck_o driven in slave mode");

  a_slave_rx: assert property (@(posedge RESET) disable iff (bclk_ok)
    slave_ph && data_latch_o && latch_cnt >= 1 |->
      rx_left_o == sent_left && rx_right_o == sent_right)
    else fail_now("slave receive samples differ from codec samples");

  a_slave_tx: assert property (@(posedge RESET) disable iff (bclk_ok)
    slave_ph && codec_chk |-> dout_o == codec_exp)
    else fail_now("slave dout_o bit differs from expected slot bit");

  initial begin : run_tests
    logic [19:0] w;
    bclk_ok   = 1'b1;
    master_i  = 1'b0;
    mode_i    = '0;
    idle_ph   = 1'b0;
    master_ph = 1'b0;
    slave_ph  = 1'b0;
    codec_en  = 1'b0;
    lfsr_q    = 16'd34;
    draw_bits(16, w);
    tx_left_i = w[15:0];
    draw_bits(16, w);
    tx_right_i = w[15:0];
    draw_bits(20, w);
    codec_word = w;

    repeat (2) @(posedge RESET);
    bclk_ok <= 1'b0;
    idle_ph <= 1'b1;
    repeat (40) @(posedge RESET);
    idle_ph <= 1'b0;

    for (int m = 0; m < 4; m++) begin
      master_i <= 1'b1;
      mode_i   <= 2'(m);
      apply_reset();
      master_ph <= 1'b1;
      wait_latches(4);
      master_ph <= 1'b0;
    end

    master_i <= 1'b0;
    apply_reset();
    codec_en <= 1'b1;
    slave_ph <= 1'b1;
    wait_latches(5);
    slave_ph <= 1'b0;
    @(posedge RESET);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tb/tb_dai_codec.sv
`timescale 1ns/1ps

module tb_dai_codec (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        en_i,
  input  logic [19:0] slot_word_i,
  input  logic [15:0] tx_left_i,
  input  logic [15:0] tx_right_i,
  output logic        bclk_o,
  output logic        lrck_o,
  output logic        din_o,
  output logic        take_o,
  output logic [15:0] sent_left_o,
  output logic [15:0] sent_right_o,
  output logic        chk_o,
  output logic        exp_bit_o
);

  logic [2:0]  ph;
  logic [4:0]  bi;
  logic [19:0] word;
  logic [1:0]  slot_cnt;
  logic [15:0] cur_sample;

  // Eight clocks per bit, lrck and data change with the falling edge.
  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ph           <= '0;
      bi           <= '0;
      word         <= '0;
      slot_cnt     <= '0;
      bclk_o       <= 1'b0;
      lrck_o       <= 1'b0;
      din_o        <= 1'b0;
      take_o       <= 1'b0;
      sent_left_o  <= '0;
      sent_right_o <= '0;
    end else if (en_i) begin
      take_o <= 1'b0;
      ph     <= ph + 3'd1;
      if (ph == 3'd0) begin
        bclk_o <= 1'b0;
        if (bi == 5'd0) begin
          lrck_o <= ~lrck_o;
          din_o  <= slot_word_i[19];
          word   <= {slot_word_i[18:0], 1'b0};
          take_o <= 1'b1;
          if (lrck_o) begin
            sent_left_o <= slot_word_i[19:4];
          end else begin
            sent_right_o <= slot_word_i[19:4];
          end
          if (slot_cnt != 2'd3) begin
            slot_cnt <= slot_cnt + 2'd1;
          end
        end else begin
          din_o <= word[19];
          word  <= {word[18:0], 1'b0};
        end
      end
      if (ph == 3'd4) begin
        bclk_o <= 1'b1;
      end
      if (ph == 3'd7) begin
        bi <= (bi == 5'd19) ? 5'd0 : bi + 5'd1;
      end
    end
  end

  // The first slot starts without a bclk fall, so checks begin with the second.
  assign cur_sample = lrck_o ? tx_right_i : tx_left_i;
  assign exp_bit_o  = (bi < 5'd16) ? cur_sample[4'd15 - bi[3:0]] : 1'b0;
  assign chk_o      = en_i && (slot_cnt >= 2'd2) && (ph == 3'd7);

endmodule

// File: src/dai_top.sv
`timescale 1ns/1ps

module dai_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                  RESET,
  input  logic                                  bclk_ok,
  input  logic                                  master_i,
  input  logic [dai_cfg_pkg::mode_width-1:0]     mode_i,
  input  logic                                  bclk_i,
  input  logic                                  lrck_i,
  input  logic                                  din_i,
  input  logic [dai_frame_pkg::sample_width-1:0] tx_left_i,
  input  logic [dai_frame_pkg::sample_width-1:0] tx_right_i,
  output logic                                  bclk_o,
  output logic                                  lrck_o,
  output logic                                  dout_o,
  output logic [dai_frame_pkg::sample_width-1:0] rx_left_o,
  output logic [dai_frame_pkg::sample_width-1:0] rx_right_o,
  output logic                                  data_latch_o
);

  logic gen_level;
  logic gen_rise;
  logic gen_fall;
  logic sample_stb;
  logic shift_stb;
  logic slot_start;
  logic slot_end;
  logic chan;

  // Divider runs only as master.
  dai_bclk_gen u_bclk_gen (
    .RESET   (RESET),
    .bclk_ok (bclk_ok),
    .mode_i  (mode_i),
    .run_i   (master_i),
    .bclk_o  (gen_level),
    .rise_o  (gen_rise),
    .fall_o  (gen_fall)
  );

  dai_frame_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_frame_ctrl (
    .RESET        (RESET),
    .bclk_ok      (bclk_ok),
    .master_i     (master_i),
    .bclk_i       (bclk_i),
    .lrck_i       (lrck_i),
    .gen_rise_i   (gen_rise),
    .gen_fall_i   (gen_fall),
    .gen_level_i  (gen_level),
    .bclk_o       (bclk_o),
    .lrck_o       (lrck_o),
    .sample_stb_o (sample_stb),
    .shift_stb_o  (shift_stb),
    .slot_start_o (slot_start),
    .slot_end_o   (slot_end),
    .chan_o       (chan)
  );

  dai_rx_deser u_rx_deser (
    .RESET        (RESET),
    .bclk_ok      (bclk_ok),
    .din_i        (din_i),
    .sample_stb_i (sample_stb),
    .slot_end_i   (slot_end),
    .chan_i       (chan),
    .rx_left_o    (rx_left_o),
    .rx_right_o   (rx_right_o),
    .data_latch_o (data_latch_o)
  );

  dai_tx_ser u_tx_ser (
    .RESET        (RESET),
    .bclk_ok      (bclk_ok),
    .shift_stb_i  (shift_stb),
    .slot_start_i (slot_start),
    .chan_i       (chan),
    .tx_left_i    (tx_left_i),
    .tx_right_i   (tx_right_i),
    .dout_o       (dout_o)
  );

endmodule

// File: src/dai_tx_ser.sv
`timescale 1ns/1ps

module dai_tx_ser (
  input  logic                                  RESET,
  input  logic                                  bclk_ok,
  input  logic                                  shift_stb_i,
  input  logic                                  slot_start_i,
  input  logic                                  chan_i,
  input  logic [dai_frame_pkg::sample_width-1:0] tx_left_i,
  input  logic [dai_frame_pkg::sample_width-1:0] tx_right_i,
  output logic                                  dout_o
);

  localparam int slot_msb = $bits(dai_frame_pkg::dai_slot_u) - 1;

  dai_frame_pkg::dai_slot_u load_word;
  dai_frame_pkg::dai_slot_u tx_word;

  // Sample of the new slot with zero pad below it.
  always_comb begin
    if (chan_i == dai_frame_pkg::chan_left) begin
      load_word.fields.sample = tx_left_i;
    end else begin
      load_word.fields.sample = tx_right_i;
    end
    load_word.fields.pad = '0;
  end

  // MSB goes out at slot start, the rest one per falling edge.
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      tx_word.raw <= '0;
      dout_o      <= 1'b0;
    end else if (slot_start_i) begin
      dout_o      <= load_word.raw[slot_msb];
      tx_word.raw <= {load_word.raw[slot_msb-1:0], 1'b0};
    end else if (shift_stb_i) begin
      dout_o      <= tx_word.raw[slot_msb];
      tx_word.raw <= {tx_word.raw[slot_msb-1:0], 1'b0};
    end
  end

endmodule

// File: src/dai_rx_deser.sv
`timescale 1ns/1ps

module dai_rx_deser (
  input  logic                                  RESET,
  input  logic                                  bclk_ok,
  input  logic                                  din_i,
  input  logic                                  sample_stb_i,
  input  logic                                  slot_end_i,
  input  logic                                  chan_i,
  output logic [dai_frame_pkg::sample_width-1:0] rx_left_o,
  output logic [dai_frame_pkg::sample_width-1:0] rx_right_o,
  output logic                                  data_latch_o
);

  localparam int slot_msb = $bits(dai_frame_pkg::dai_slot_u) - 1;

  dai_frame_pkg::dai_slot_u rx_word;
  dai_frame_pkg::dai_slot_u cap_word;
  logic                     right_cap;

  // Word including the bit arriving this cycle.
  always_comb begin
    cap_word.raw = {rx_word.raw[slot_msb-1:0], din_i};
  end

  always_ff @(posedge RESET) begin
    if (sample_stb_i) begin
      rx_word.raw <= cap_word.raw;
    end
  end

  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      rx_left_o  <= '0;
      rx_right_o <= '0;
    end else if (slot_end_i) begin
      if (chan_i == dai_frame_pkg::chan_right) begin
        rx_right_o <= cap_word.fields.sample;
      end else begin
        rx_left_o <= cap_word.fields.sample;
      end
    end
  end

  // Frame is complete once the right channel has landed.
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      right_cap    <= 1'b0;
      data_latch_o <= 1'b0;
    end else begin
      right_cap    <= slot_end_i && (chan_i == dai_frame_pkg::chan_right);
      data_latch_o <= right_cap;
    end
  end

  a_latch_pulse: assert property (
    @(posedge RESET) disable iff (bclk_ok)
    data_latch_o |=> !data_latch_o
  ) else $error("data_latch_o held for more than one cycle");

endmodule

// File: src/dai_frame_ctrl.sv
`timescale 1ns/1ps

module dai_frame_ctrl #(
  parameter int SYNC_STAGES = 2
) (
  input  logic RESET,
  input  logic bclk_ok,
  input  logic master_i,
  input  logic bclk_i,
  input  logic lrck_i,
  input  logic gen_rise_i,
  input  logic gen_fall_i,
  input  logic gen_level_i,
  output logic bclk_o,
  output logic lrck_o,
  output logic sample_stb_o,
  output logic shift_stb_o,
  output logic slot_start_o,
  output logic slot_end_o,
  output logic chan_o
);

  localparam int cw = dai_cfg_pkg::cnt_width;
  localparam logic [cw-1:0] last_bit = cw'(dai_cfg_pkg::slot_bits - 1);

  logic [SYNC_STAGES-1:0] bclk_sync;
  logic [SYNC_STAGES-1:0] lrck_sync;
  logic                   bclk_d;
  logic                   bclk_s;
  logic                   lrck_s;
  logic                   ext_rise;
  logic                   ext_fall;
  logic                   src_rise;
  logic                   src_fall;
  logic                   lrck_gen;
  logic                   lrck_toggle;
  logic                   lrck_next;
  logic                   lrck_cur;
  logic                   new_slot;
  logic [cw-1:0]          fall_cnt;
  logic [cw-1:0]          bit_cnt;

  // External bit clock and word select.
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      bclk_sync <= '0;
      lrck_sync <= '0;
      bclk_d    <= 1'b0;
    end else begin
      bclk_sync <= {bclk_sync[SYNC_STAGES-2:0], bclk_i};
      lrck_sync <= {lrck_sync[SYNC_STAGES-2:0], lrck_i};
      bclk_d    <= bclk_s;
    end
  end

  assign bclk_s   = bclk_sync[SYNC_STAGES-1];
  assign lrck_s   = lrck_sync[SYNC_STAGES-1];
  assign ext_rise = bclk_s & ~bclk_d;
  assign ext_fall = ~bclk_s & bclk_d;

  assign src_rise = master_i ? gen_rise_i : ext_rise;
  assign src_fall = master_i ? gen_fall_i : ext_fall;

  // Master lrck flips after every 18th falling edge.
  assign lrck_toggle = gen_fall_i && (fall_cnt == last_bit);
  assign lrck_next   = lrck_gen ^ lrck_toggle;

  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      fall_cnt <= '0;
      lrck_gen <= 1'b0;
    end else if (!master_i) begin
      fall_cnt <= '0;
      lrck_gen <= 1'b0;
    end else if (gen_fall_i) begin
      if (lrck_toggle) begin
        fall_cnt <= '0;
        lrck_gen <= ~lrck_gen;
      end else begin
        fall_cnt <= fall_cnt + 1'b1;
      end
    end
  end

  // A slot opens on the first falling edge that sees a new lrck level.
  assign lrck_cur = master_i ? lrck_next : lrck_s;
  assign new_slot = src_fall && (lrck_cur != chan_o);

  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      sample_stb_o <= 1'b0;
      shift_stb_o  <= 1'b0;
      slot_start_o <= 1'b0;
      slot_end_o   <= 1'b0;
      chan_o       <= 1'b0;
      bit_cnt      <= '1;
    end else begin
      sample_stb_o <= src_rise;
      shift_stb_o  <= src_fall;
      slot_start_o <= new_slot;
      slot_end_o   <= src_rise && (bit_cnt == last_bit);
      if (new_slot) begin
        chan_o  <= lrck_cur;
        bit_cnt <= '0;
      end else if (src_rise && (bit_cnt != '1)) begin
        // Saturate so long slots give no extra end strobe.
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign bclk_o = master_i ? gen_level_i : 1'b0;
  assign lrck_o = master_i ? lrck_gen : 1'b0;

  a_stb_excl: assert property (
    @(posedge RESET) disable iff (bclk_ok)
    !(sample_stb_o && shift_stb_o)
  ) else $error("sample and shift strobes overlap");

endmodule

// File: src/dai_bclk_gen.sv
`timescale 1ns/1ps

module dai_bclk_gen (
  input  logic                                RESET,
  input  logic                                bclk_ok,
  input  logic [dai_cfg_pkg::mode_width-1:0]  mode_i,
  input  logic                                run_i,
  output logic                                bclk_o,
  output logic                                rise_o,
  output logic                                fall_o
);

  localparam int dw = dai_cfg_pkg::div_width;

  logic [dw:0]   half;
  logic [dw:0]   half_m1;
  logic [dw-1:0] div_cnt;

  assign half    = dai_cfg_pkg::half_period(mode_i);
  assign half_m1 = half - 1'b1;

  // Down-counter toggles the level each time it reaches zero.
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      div_cnt <= '0;
      bclk_o  <= 1'b0;
      rise_o  <= 1'b0;
      fall_o  <= 1'b0;
    end else if (!run_i) begin
      // Slave mode keeps the divider parked.
      div_cnt <= '0;
      bclk_o  <= 1'b0;
      rise_o  <= 1'b0;
      fall_o  <= 1'b0;
    end else begin
      rise_o <= 1'b0;
      fall_o <= 1'b0;
      if (div_cnt == '0) begin
        div_cnt <= half_m1[dw-1:0];
        bclk_o  <= ~bclk_o;
        rise_o  <= ~bclk_o;
        fall_o  <= bclk_o;
      end else begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

  a_edge_excl: assert property (
    @(posedge RESET) disable iff (bclk_ok)
    !(rise_o && fall_o)
  ) else $error("bit-clock rise and fall strobes overlap");

endmodule

// File: src/dai_frame_pkg.sv
package dai_frame_pkg;

  // Audio sample width, left-justified in the slot.
  localparam int sample_width = 16;

  // Zero bits following the sample inside a slot.
  localparam int pad_width = dai_cfg_pkg::slot_bits - sample_width;

  // One slot word, seen as shift register bits or as sample over pad.
  typedef union packed {
    logic [dai_cfg_pkg::slot_bits-1:0] raw;
    struct packed {
      logic [sample_width-1:0] sample;
      logic [pad_width-1:0]    pad;
    } fields;
  } dai_slot_u;

  // Channel encoding follows the lrck level.
  localparam logic chan_left  = 1'b0;
  localparam logic chan_right = 1'b1;

endpackage

// File: src/dai_cfg_pkg.sv
package dai_cfg_pkg;

  // Width of the bit-clock divide-mode select.
  localparam int mode_width = 2;

  // Divider counter holds half_period minus one.
  localparam int div_width = 3;

  // Data bits carried in each channel slot.
  localparam int slot_bits = 18;

  // Slot bit counter, saturating at its all-ones value.
  localparam int cnt_width = 5;

  // Bit-clock half period in system clocks for each mode.
  function automatic logic [div_width:0] half_period(input logic [mode_width-1:0] mode);
    case (mode)
      2'd0:    return 4'd1;
      2'd1:    return 4'd2;
      2'd2:    return 4'd4;
      default: return 4'd8;
    endcase
  endfunction

endpackage
